// File: logic/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter import core_pkg::*; (
  input  logic  clock,
  input  logic  reset,
  input  logic  host_req_valid,
  output logic  host_req_ready,
  input  logic  host_req_write,
  input  addr_t host_req_addr,
  input  word_t host_req_wdata,
  output logic  host_rsp_valid,
  output word_t host_rsp_rdata,
  input  logic  lsu_req_valid,
  output logic  lsu_req_ready,
  input  logic  lsu_req_write,
  input  addr_t lsu_req_addr,
  input  word_t lsu_req_wdata,
  output logic  lsu_rsp_valid,
  output word_t lsu_rsp_rdata,
  input  logic  fetch_req_valid,
  output logic  fetch_req_ready,
  input  addr_t fetch_req_addr,
  output logic  fetch_rsp_valid,
  output word_t fetch_rsp_rdata,
  output logic  mem_req_valid,
  output logic  mem_req_write,
  output addr_t mem_req_addr,
  output word_t mem_req_wdata,
  input  logic  mem_rsp_valid,
  input  word_t mem_rsp_rdata
);

  logic [bus_peers-1:0] grant;
  logic [bus_peers-1:0] owner; // One-hot owner of the open transfer.
  logic idle;

  assign idle     = owner == '0;
  assign grant[0] = idle && host_req_valid;
  assign grant[1] = idle && lsu_req_valid && !host_req_valid;
  assign grant[2] = idle && fetch_req_valid && !host_req_valid && !lsu_req_valid;

  assign host_req_ready  = grant[0];
  assign lsu_req_ready   = grant[1];
  assign fetch_req_ready = grant[2];

  assign mem_req_valid = |grant;
  assign mem_req_write = (grant[0] && host_req_write) || (grant[1] && lsu_req_write);
  assign mem_req_addr  = grant[0] ? host_req_addr : grant[1] ? lsu_req_addr : fetch_req_addr;
  assign mem_req_wdata = grant[0] ? host_req_wdata : lsu_req_wdata;

  assign host_rsp_valid  = mem_rsp_valid && owner[0];
  assign lsu_rsp_valid   = mem_rsp_valid && owner[1];
  assign fetch_rsp_valid = mem_rsp_valid && owner[2];
  assign host_rsp_rdata  = mem_rsp_rdata;
  assign lsu_rsp_rdata   = mem_rsp_rdata;
  assign fetch_rsp_rdata = mem_rsp_rdata;

  always_ff @(posedge clock) begin
    if (reset) owner <= '0;
    else if (mem_rsp_valid) owner <= '0;
    else if (mem_req_valid) owner <= grant;
  end

endmodule

// File: logic/core_pkg.sv
package core_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [4:0]  reg_idx_t;

  typedef enum logic [6:0] {
    op_lui    = 7'b0110111,
    op_auipc  = 7'b0010111,
    op_jal    = 7'b1101111,
    op_jalr   = 7'b1100111,
    op_branch = 7'b1100011,
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_imm    = 7'b0010011,
    op_reg    = 7'b0110011
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor,
    alu_slt, alu_pass_b, alu_eq, alu_ne, alu_lt
  } alu_op_e;

  typedef enum logic [1:0] {npc_seq, npc_jal, npc_jalr, npc_branch} npc_sel_e;

  typedef enum logic [1:0] {wb_alu, wb_seq, wb_target} wb_sel_e;

  typedef enum logic [1:0] {mem_none, mem_load, mem_store} mem_op_e;

  localparam addr_t reset_pc = 32'h0000_0000;
  localparam int mem_words = 1024;
  localparam int mem_addr_bits = $clog2(mem_words);
  localparam int bus_peers = 3; // Host, load/store, fetch.

endpackage

// File: logic/core_top.sv
`timescale 1ns/1ps

module core_top import core_pkg::*; (
  input  logic     clock,
  input  logic     reset,
  input  logic     run,
  input  logic     host_req_valid,
  output logic     host_req_ready,
  input  logic     host_req_write,
  input  addr_t    host_req_addr,
  input  word_t    host_req_wdata,
  output logic     host_rsp_valid,
  output word_t    host_rsp_rdata,
  output logic     retire_valid,
  output addr_t    retire_pc,
  output reg_idx_t retire_rd,
  output word_t    retire_value
);

  logic     redirect;
  addr_t    redirect_pc;
  logic     f_valid, f_ready;
  addr_t    f_pc;
  word_t    f_instr;
  logic     d_valid, d_ready, d_operand2_imm;
  word_t    d_pc, d_imm, d_src1, d_src2;
  reg_idx_t d_rd;
  alu_op_e  d_alu_op;
  npc_sel_e d_npc_sel;
  wb_sel_e  d_wb_sel;
  mem_op_e  d_mem_op;
  logic     e_valid, e_ready;
  addr_t    e_pc;
  reg_idx_t e_rd;
  word_t    e_value, e_store_data;
  mem_op_e  e_mem_op;
  logic     wb_valid;
  reg_idx_t wb_rd;
  word_t    wb_value;
  logic     fetch_req_valid, fetch_req_ready, fetch_rsp_valid;
  addr_t    fetch_req_addr;
  word_t    fetch_rsp_rdata;
  logic     lsu_req_valid, lsu_req_ready, lsu_req_write, lsu_rsp_valid;
  addr_t    lsu_req_addr;
  word_t    lsu_req_wdata, lsu_rsp_rdata;
  logic     mem_req_valid, mem_req_write, mem_rsp_valid;
  addr_t    mem_req_addr;
  word_t    mem_req_wdata, mem_rsp_rdata;

  fetch_unit i_fetch_unit (
    .clock, .reset, .run, .redirect, .redirect_pc,
    .f_valid, .f_ready, .f_pc, .f_instr,
    .req_valid(fetch_req_valid), .req_ready(fetch_req_ready), .req_addr(fetch_req_addr),
    .rsp_valid(fetch_rsp_valid), .rsp_rdata(fetch_rsp_rdata)
  );

  decode_unit i_decode_unit (
    .clock, .reset, .f_valid, .f_ready, .f_pc, .f_instr, .flush(redirect),
    .d_valid, .d_ready, .d_pc, .d_imm, .d_src1, .d_src2, .d_rd, .d_alu_op,
    .d_operand2_imm, .d_npc_sel, .d_wb_sel, .d_mem_op, .wb_valid, .wb_rd, .wb_value
  );

  execute_unit i_execute_unit (
    .clock, .reset, .d_valid, .d_ready, .d_pc, .d_imm, .d_src1, .d_src2, .d_rd,
    .d_alu_op, .d_operand2_imm, .d_npc_sel, .d_wb_sel, .d_mem_op, .redirect, .redirect_pc,
    .e_valid, .e_ready, .e_pc, .e_rd, .e_value, .e_store_data, .e_mem_op
  );

  load_store_unit i_load_store_unit (
    .clock, .reset, .e_valid, .e_ready, .e_pc, .e_rd, .e_value, .e_store_data, .e_mem_op,
    .req_valid(lsu_req_valid), .req_ready(lsu_req_ready), .req_write(lsu_req_write),
    .req_addr(lsu_req_addr), .req_wdata(lsu_req_wdata),
    .rsp_valid(lsu_rsp_valid), .rsp_rdata(lsu_rsp_rdata),
    .wb_valid, .wb_rd, .wb_value, .retire_valid, .retire_pc, .retire_rd, .retire_value
  );

  bus_arbiter i_bus_arbiter (
    .clock, .reset,
    .host_req_valid, .host_req_ready, .host_req_write, .host_req_addr, .host_req_wdata,
    .host_rsp_valid, .host_rsp_rdata,
    .lsu_req_valid, .lsu_req_ready, .lsu_req_write, .lsu_req_addr, .lsu_req_wdata,
    .lsu_rsp_valid, .lsu_rsp_rdata,
    .fetch_req_valid, .fetch_req_ready, .fetch_req_addr, .fetch_rsp_valid, .fetch_rsp_rdata,
    .mem_req_valid, .mem_req_write, .mem_req_addr, .mem_req_wdata,
    .mem_rsp_valid, .mem_rsp_rdata
  );

  word_memory i_word_memory (
    .clock, .req_valid(mem_req_valid), .req_write(mem_req_write), .req_addr(mem_req_addr),
    .req_wdata(mem_req_wdata), .rsp_valid(mem_rsp_valid), .rsp_rdata(mem_rsp_rdata)
  );

endmodule

// File: logic/decode_unit.sv
`timescale 1ns/1ps

module decode_unit import core_pkg::*; (
  input  logic     clock,
  input  logic     reset,
  input  logic     f_valid,
  output logic     f_ready,
  input  addr_t    f_pc,
  input  word_t    f_instr,
  input  logic     flush,
  output logic     d_valid,
  input  logic     d_ready,
  output word_t    d_pc,
  output word_t    d_imm,
  output word_t    d_src1,
  output word_t    d_src2,
  output reg_idx_t d_rd,
  output alu_op_e  d_alu_op,
  output logic     d_operand2_imm,
  output npc_sel_e d_npc_sel,
  output wb_sel_e  d_wb_sel,
  output mem_op_e  d_mem_op,
  input  logic     wb_valid,
  input  reg_idx_t wb_rd,
  input  word_t    wb_value
);

  word_t    regs [32];
  logic [31:0] pending;
  logic     held;
  word_t    instr;
  addr_t    f_pc_q;
  opcode_e  opcode;
  reg_idx_t rs1, rs2;
  logic     use_rs1, use_rs2, writes_rd;
  logic     rs1_wait, rs2_wait, rd_wait;
  logic     issue;

  assign opcode = opcode_e'(instr[6:0]);
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign d_rd   = writes_rd ? instr[11:7] : '0;

  always_comb begin
    d_alu_op       = alu_add;
    d_operand2_imm = 1'b1;
    d_npc_sel      = npc_seq;
    d_wb_sel       = wb_alu;
    d_mem_op       = mem_none;
    d_imm          = {{20{instr[31]}}, instr[31:20]};
    writes_rd      = 1'b1;
    use_rs1        = 1'b1;
    use_rs2        = 1'b0;
    case (opcode)
      op_lui: begin
        d_alu_op = alu_pass_b;
        d_imm    = {instr[31:12], 12'b0};
        use_rs1  = 1'b0;
      end
      op_auipc: begin
        d_wb_sel = wb_target;
        d_imm    = {instr[31:12], 12'b0};
        use_rs1  = 1'b0;
      end
      op_jal: begin
        d_npc_sel = npc_jal;
        d_wb_sel  = wb_seq;
        d_imm     = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
        use_rs1   = 1'b0;
      end
      op_jalr: begin
        d_npc_sel = npc_jalr;
        d_wb_sel  = wb_seq;
      end
      op_branch: begin
        d_npc_sel      = npc_branch;
        d_operand2_imm = 1'b0;
        d_imm     = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
        writes_rd = 1'b0;
        use_rs2   = 1'b1;
        case (instr[14:12])
          3'b001:  d_alu_op = alu_ne;
          3'b100:  d_alu_op = alu_lt;
          default: d_alu_op = alu_eq;
        endcase
      end
      op_load: d_mem_op = mem_load;
      op_store: begin
        d_mem_op  = mem_store;
        d_imm     = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        writes_rd = 1'b0;
        use_rs2   = 1'b1;
      end
      op_imm: ; // Only addi.
      op_reg: begin
        d_operand2_imm = 1'b0;
        use_rs2        = 1'b1;
        case (instr[14:12])
          3'b111:  d_alu_op = alu_and;
          3'b110:  d_alu_op = alu_or;
          3'b100:  d_alu_op = alu_xor;
          3'b010:  d_alu_op = alu_slt;
          default: d_alu_op = instr[30] ? alu_sub : alu_add;
        endcase
      end
      default: begin // Unsupported, retires as a nop.
        writes_rd = 1'b0;
        use_rs1   = 1'b0;
      end
    endcase
  end

  // Register read with same-cycle writeback bypass.
  assign d_src1 = (rs1 == '0) ? '0 : (wb_valid && wb_rd == rs1) ? wb_value : regs[rs1];
  assign d_src2 = (rs2 == '0) ? '0 : (wb_valid && wb_rd == rs2) ? wb_value : regs[rs2];

  assign rs1_wait = use_rs1 && pending[rs1] && !(wb_valid && wb_rd == rs1);
  assign rs2_wait = use_rs2 && pending[rs2] && !(wb_valid && wb_rd == rs2);
  assign rd_wait  = pending[d_rd] && !(wb_valid && wb_rd == d_rd); // Keeps writebacks ordered.

  assign d_valid = held && !rs1_wait && !rs2_wait && !rd_wait;
  assign d_pc    = f_pc_q;
  assign issue   = d_valid && d_ready;
  assign f_ready = !flush && (!held || issue);

  always_ff @(posedge clock) begin
    if (reset) begin
      held    <= 1'b0;
      pending <= '0;
    end else begin
      if (flush) held <= 1'b0;
      else if (f_valid && f_ready) held <= 1'b1;
      else if (issue) held <= 1'b0;
      if (wb_valid) pending[wb_rd] <= 1'b0;
      if (issue && d_rd != '0) pending[d_rd] <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (f_valid && f_ready) begin
      instr  <= f_instr;
      f_pc_q <= f_pc;
    end
    if (wb_valid) regs[wb_rd] <= wb_value;
  end

endmodule

// File: logic/execute_unit.sv
`timescale 1ns/1ps

module execute_unit import core_pkg::*; (
  input  logic     clock,
  input  logic     reset,
  input  logic     d_valid,
  output logic     d_ready,
  input  word_t    d_pc,
  input  word_t    d_imm,
  input  word_t    d_src1,
  input  word_t    d_src2,
  input  reg_idx_t d_rd,
  input  alu_op_e  d_alu_op,
  input  logic     d_operand2_imm,
  input  npc_sel_e d_npc_sel,
  input  wb_sel_e  d_wb_sel,
  input  mem_op_e  d_mem_op,
  output logic     redirect,
  output addr_t    redirect_pc,
  output logic     e_valid,
  input  logic     e_ready,
  output addr_t    e_pc,
  output reg_idx_t e_rd,
  output word_t    e_value,
  output word_t    e_store_data,
  output mem_op_e  e_mem_op
);

  function automatic word_t alu(alu_op_e op, word_t a, word_t b);
    case (op)
      alu_sub:         return a - b;
      alu_and:         return a & b;
      alu_or:          return a | b;
      alu_xor:         return a ^ b;
      alu_slt, alu_lt: return {31'b0, $signed(a) < $signed(b)};
      alu_pass_b:      return b;
      alu_eq:          return {31'b0, a == b};
      alu_ne:          return {31'b0, a != b};
      default:         return a + b;
    endcase
  endfunction

  word_t    operand1, operand2;
  addr_t    snpc, dnpc;
  alu_op_e  alu_op_q;
  npc_sel_e npc_sel_q;
  wb_sel_e  wb_sel_q;
  word_t    alu_result;
  addr_t    npc;
  logic     fresh; // First cycle of the held result.

  assign alu_result = alu(alu_op_q, operand1, operand2);

  always_comb begin
    case (npc_sel_q)
      npc_jal:    npc = dnpc;
      npc_jalr:   npc = alu_result & ~32'd1;
      npc_branch: npc = alu_result[0] ? dnpc : snpc;
      default:    npc = snpc;
    endcase
    case (wb_sel_q)
      wb_seq:    e_value = snpc;
      wb_target: e_value = dnpc;
      default:   e_value = alu_result;
    endcase
  end

  assign redirect    = fresh && npc != snpc;
  assign redirect_pc = npc;
  assign d_ready     = (!e_valid || e_ready) && !redirect; // Wrong-path item stays out.

  always_ff @(posedge clock) begin
    if (reset) begin
      e_valid <= 1'b0;
      fresh   <= 1'b0;
    end else begin
      fresh <= d_valid && d_ready;
      if (d_valid && d_ready) e_valid <= 1'b1;
      else if (e_ready) e_valid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (d_valid && d_ready) begin
      operand1     <= d_src1;
      operand2     <= d_operand2_imm ? d_imm : d_src2;
      snpc         <= d_pc + 32'd4;
      dnpc         <= d_pc + d_imm;
      alu_op_q     <= d_alu_op;
      npc_sel_q    <= d_npc_sel;
      wb_sel_q     <= d_wb_sel;
      e_pc         <= d_pc;
      e_rd         <= d_rd;
      e_store_data <= d_src2;
      e_mem_op     <= d_mem_op;
    end
  end

endmodule

// File: logic/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit import core_pkg::*; (
  input  logic  clock,
  input  logic  reset,
  input  logic  run,
  input  logic  redirect,
  input  addr_t redirect_pc,
  output logic  f_valid,
  input  logic  f_ready,
  output addr_t f_pc,
  output word_t f_instr,
  output logic  req_valid,
  input  logic  req_ready,
  output addr_t req_addr,
  input  logic  rsp_valid,
  input  word_t rsp_rdata
);

  addr_t pc;
  addr_t rd_pc;   // Address of the outstanding read.
  logic  waiting;
  logic  drop;

  assign req_valid = run && !waiting && !f_valid && !redirect;
  assign req_addr  = pc;

  always_ff @(posedge clock) begin
    if (reset) begin
      pc      <= reset_pc;
      waiting <= 1'b0;
      drop    <= 1'b0;
      f_valid <= 1'b0;
    end else begin
      if (f_valid && f_ready) f_valid <= 1'b0;
      if (req_valid && req_ready) begin
        waiting <= 1'b1;
        rd_pc   <= pc;
        pc      <= pc + 32'd4;
      end
      if (rsp_valid && waiting) begin
        waiting <= 1'b0;
        drop    <= 1'b0;
        if (!drop && !redirect) begin
          f_valid <= 1'b1;
          f_pc    <= rd_pc;
          f_instr <= rsp_rdata;
        end
      end
      if (redirect) begin
        pc      <= redirect_pc;
        f_valid <= 1'b0;
        if (waiting && !rsp_valid) drop <= 1'b1; // Stale read still in flight.
      end
    end
  end

endmodule

// File: logic/load_store_unit.sv
`timescale 1ns/1ps

module load_store_unit import core_pkg::*; (
  input  logic     clock,
  input  logic     reset,
  input  logic     e_valid,
  output logic     e_ready,
  input  addr_t    e_pc,
  input  reg_idx_t e_rd,
  input  word_t    e_value,
  input  word_t    e_store_data,
  input  mem_op_e  e_mem_op,
  output logic     req_valid,
  input  logic     req_ready,
  output logic     req_write,
  output addr_t    req_addr,
  output word_t    req_wdata,
  input  logic     rsp_valid,
  input  word_t    rsp_rdata,
  output logic     wb_valid,
  output reg_idx_t wb_rd,
  output word_t    wb_value,
  output logic     retire_valid,
  output addr_t    retire_pc,
  output reg_idx_t retire_rd,
  output word_t    retire_value
);

  typedef enum logic [1:0] {ls_idle, ls_req, ls_rsp} ls_state_e;

  ls_state_e state;
  logic      take;

  assign take      = e_valid && e_ready;
  assign e_ready   = state == ls_idle;
  assign req_valid = state == ls_req;

  assign wb_valid = retire_valid && retire_rd != '0;
  assign wb_rd    = retire_rd;
  assign wb_value = retire_value;

  always_ff @(posedge clock) begin
    if (reset) begin
      state        <= ls_idle;
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= 1'b0;
      case (state)
        ls_idle: begin
          if (take && e_mem_op == mem_none) retire_valid <= 1'b1;
          else if (take) state <= ls_req;
        end
        ls_req: if (req_ready) state <= ls_rsp;
        ls_rsp: begin
          if (rsp_valid) begin
            retire_valid <= 1'b1;
            state        <= ls_idle;
          end
        end
        default: state <= ls_idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (take) begin
      retire_pc    <= e_pc;
      retire_rd    <= (e_mem_op == mem_store) ? '0 : e_rd;
      retire_value <= e_value; // Address for stores.
      req_addr     <= e_value;
      req_wdata    <= e_store_data;
      req_write    <= e_mem_op == mem_store;
    end
    if (state == ls_rsp && rsp_valid && !req_write) retire_value <= rsp_rdata;
  end

endmodule

// File: logic/word_memory.sv
`timescale 1ns/1ps

module word_memory import core_pkg::*; (
  input  logic  clock,
  input  logic  req_valid,
  input  logic  req_write,
  input  addr_t req_addr,
  input  word_t req_wdata,
  output logic  rsp_valid,
  output word_t rsp_rdata
);

  word_t mem [mem_words];
  logic [mem_addr_bits-1:0] index;

  assign index = req_addr[mem_addr_bits+1:2]; // Word index.

  always_ff @(posedge clock) begin
    rsp_valid <= req_valid; // Stores are acknowledged too.
    if (req_valid) begin
      rsp_rdata <= mem[index];
      if (req_write) mem[index] <= req_wdata;
    end
  end

endmodule

// File: run.sh
#!/bin/sh
# Builds the core testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module core_tb -f src.f -o core_tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/core_tb_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "TEST FAILED" sim.log; then
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi
exit 0

// File: src.f
logic/core_pkg.sv
logic/fetch_unit.sv
logic/decode_unit.sv
logic/execute_unit.sv
logic/load_store_unit.sv
logic/bus_arbiter.sv
logic/word_memory.sv
logic/core_top.sv
verification/core_tb.sv

// File: verification/core_input.txt
// Counts: program words, retire records, memory checks. Then program words from address 0,
// retire records (pc rd value) and memory checks (address value), all in hex.
0000001d 00000017 00000003
00500093 00300113 002081b3 40218233
0011f2b3 0011e333 002343b3 00112433
123454b7 00001517 00408463 06300593
00409463 00114463 04d00593 0080066f
03700593 00208463 0020c463 00209463
02100593 06100693 00068767 00b00593
20302023 20002783 00678833 21002223
0000006f
00000000 00000001 00000005
00000004 00000002 00000003
00000008 00000003 00000008
0000000c 00000004 00000005
00000010 00000005 00000000
00000014 00000006 0000000d
00000018 00000007 0000000e
0000001c 00000008 00000001
00000020 00000009 12345000
00000024 0000000a 00001024
00000028 00000000 00000001
00000030 00000000 00000000
00000034 00000000 00000001
0000003c 0000000c 00000040
00000044 00000000 00000000
00000048 00000000 00000000
0000004c 00000000 00000001
00000054 0000000d 00000061
00000058 0000000e 0000005c
00000060 00000000 00000200
00000064 0000000f 00000008
00000068 00000010 00000015
0000006c 00000000 00000204
00000200 00000008
00000204 00000015
00000070 0000006f

// File: verification/core_tb.sv
`timescale 1ns/1ps

module core_tb import core_pkg::*; ();

  logic     clock;
  logic     reset;
  logic     run;
  logic     host_req_valid;
  logic     host_req_ready;
  logic     host_req_write;
  addr_t    host_req_addr;
  word_t    host_req_wdata;
  logic     host_rsp_valid;
  word_t    host_rsp_rdata;
  logic     retire_valid;
  addr_t    retire_pc;
  reg_idx_t retire_rd;
  word_t    retire_value;

  word_t stim [256]; // Counts, program, retire records, memory checks.
  int    prog_count;
  int    retire_count;
  int    check_count;
  int    retire_base;
  int    check_base;

  core_top i_core_top (
    .clock, .reset, .run,
    .host_req_valid, .host_req_ready, .host_req_write, .host_req_addr, .host_req_wdata,
    .host_rsp_valid, .host_rsp_rdata,
    .retire_valid, .retire_pc, .retire_rd, .retire_value
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic compare_value(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("** Error: %s: expected %h, actual %h",
                                  name, expected, actual));
    end
  endtask

  // One host transfer; the response must come exactly one cycle after acceptance.
  task automatic host_access(input logic write, input addr_t addr, input word_t wdata,
                             output word_t rdata);
    int cycles;
    cycles = 0;
    @(negedge clock);
    host_req_valid = 1'b1;
    host_req_write = write;
    host_req_addr  = addr;
    host_req_wdata = wdata;
    #1; // Let the grant settle.
    while (!host_req_ready) begin
      if (cycles == 100) begin
        stop_with_failure($sformatf("Host request to address %h was never accepted", addr));
      end
      cycles++;
      @(negedge clock);
    end
    @(negedge clock); // Accepted on the rising edge before this one.
    host_req_valid = 1'b0;
    compare_value($sformatf("host response to %h", addr), 32'd1, {31'b0, host_rsp_valid});
    rdata = host_rsp_rdata;
    @(negedge clock);
    compare_value($sformatf("single response to %h", addr), 32'd0, {31'b0, host_rsp_valid});
  endtask

  task automatic wait_retire(input string what);
    int cycles;
    cycles = 0;
    @(negedge clock);
    while (!retire_valid) begin
      if (cycles == 200) begin
        stop_with_failure($sformatf("No instruction retired while waiting for %s", what));
      end
      cycles++;
      @(negedge clock);
    end
  endtask

  initial begin
    word_t rdata;
    addr_t loop_pc;
    reset          = 1'b1;
    run            = 1'b0;
    host_req_valid = 1'b0;
    host_req_write = 1'b0;
    host_req_addr  = '0;
    host_req_wdata = '0;
    void'($urandom(30772));

    $readmemh("verification/core_input.txt", stim);
    prog_count   = int'(stim[0]);
    retire_count = int'(stim[1]);
    check_count  = int'(stim[2]);
    retire_base  = 3 + prog_count;
    check_base   = retire_base + 3 * retire_count;
    if (prog_count < 1 || prog_count > 128 || check_base + 2 * check_count > 256) begin
      stop_with_failure("The data file is missing or its counts are out of range");
    end

    repeat (10) @(negedge clock);
    reset = 1'b0;
    @(negedge clock);
    compare_value("retire after reset", 32'd0, {31'b0, retire_valid});
    compare_value("host response after reset", 32'd0, {31'b0, host_rsp_valid});

    // Program load with the core halted.
    for (int i = 0; i < prog_count; i++) begin
      repeat ($urandom % 4) @(negedge clock);
      host_access(1'b1, addr_t'(i * 4), stim[3 + i], rdata);
    end

    @(negedge clock);
    run = 1'b1;

    for (int i = 0; i < retire_count; i++) begin
      wait_retire($sformatf("retire record %0d", i));
      compare_value($sformatf("retire %0d pc", i), stim[retire_base + 3 * i], retire_pc);
      compare_value($sformatf("retire %0d rd", i), stim[retire_base + 3 * i + 1],
                    {27'b0, retire_rd});
      compare_value($sformatf("retire %0d value", i), stim[retire_base + 3 * i + 2],
                    retire_value);
    end

    // Last program word is a jump to itself.
    loop_pc = addr_t'((prog_count - 1) * 4);
    for (int i = 0; i < 2; i++) begin
      wait_retire("self-loop");
      compare_value($sformatf("self-loop retire %0d pc", i), loop_pc, retire_pc);
    end

    // Readback while fetch keeps using the bus.
    for (int i = 0; i < check_count; i++) begin
      repeat ($urandom % 4) @(negedge clock);
      host_access(1'b0, stim[check_base + 2 * i], '0, rdata);
      compare_value($sformatf("memory word at %h", stim[check_base + 2 * i]),
                    stim[check_base + 2 * i + 1], rdata);
    end

    $display("TEST OK");
    $finish;
  end

endmodule
